// File: build.f
+incdir+include
hdl/exec_pkg.sv
hdl/exec_alu_1clk.sv
hdl/exec_mul_pipe.sv
hdl/exec_div_serial.sv
hdl/exec_wb_regs.sv
hdl/exec_top.sv
verification/exec_tb.sv

// File: hdl/exec_alu_1clk.sv
`timescale 1ns/1ps
/*
  One-cycle ALU of the execute stage: adder, set-flag comparator, logic unit
  and barrel shifter. The selected result and the comparison flag register
  on padv_wb_i; carry-out and overflow go to the writeback registers.
*/
module exec_alu_1clk (
  input  logic                clk,
  input  logic                rst,
  input  logic                padv_wb_i,
  input  logic                pipeline_flush_i,
  input  exec_pkg::operands_t operands_i,
  input  exec_pkg::alu_ctrl_t alu_ctrl_i,
  input  logic                exec_insn_1clk_i,
  output exec_pkg::unit_res_t alu_res_o,
  output logic                flag_set_o,
  output logic                flag_clear_o,
  output logic                add_carry_o,
  output logic                add_ovf_o
);

  exec_pkg::word_t op_a;
  exec_pkg::word_t op_b;
  exec_pkg::word_t b_mux;
  exec_pkg::word_t add_res;
  exec_pkg::word_t logic_res;
  exec_pkg::word_t shift_lsw;
  exec_pkg::word_t shift_msw;
  exec_pkg::word_t shift_right;
  exec_pkg::word_t shift_res;
  exec_pkg::word_t res_mux;
  exec_pkg::word_t result_q;
  logic            rdy_q;
  logic            carry_in;
  logic            add_cout;
  logic            a_eq_b;
  logic            a_lts_b;
  logic            a_ltu_b;
  logic            flag_cmp;
  logic [3:0]      logic_lut;
  logic [1:0]      shr_opc;

  function automatic exec_pkg::word_t bit_rev(input exec_pkg::word_t x);
    exec_pkg::word_t y;
    for (int i = 0; i < exec_pkg::DATA_W; i++) begin
      y[exec_pkg::DATA_W-1-i] = x[i];
    end
    return y;
  endfunction

  assign op_a  = operands_i.rfa;
  assign op_b  = operands_i.imm_sel ? operands_i.immediate : operands_i.rfb;
  assign b_mux = alu_ctrl_i.do_sub ? ~op_b : op_b;  // subtract is A + ~B + 1
  assign carry_in = alu_ctrl_i.do_sub | (alu_ctrl_i.do_carry & alu_ctrl_i.carry_in);
  assign {add_cout, add_res} = op_a + b_mux + exec_pkg::word_t'(carry_in);

  assign add_carry_o = add_cout;
  assign add_ovf_o   = (op_a[exec_pkg::DATA_W-1] == b_mux[exec_pkg::DATA_W-1]) &
                       (op_a[exec_pkg::DATA_W-1] ^ add_res[exec_pkg::DATA_W-1]);

  // relations come from the subtract
  assign a_eq_b  = (op_a == op_b);
  assign a_lts_b = add_res[exec_pkg::DATA_W-1] ^ add_ovf_o;
  assign a_ltu_b = ~add_cout;  // borrow

  always_comb begin
    case (alu_ctrl_i.opc_secondary)
      exec_pkg::CMP_EQ:  flag_cmp = a_eq_b;
      exec_pkg::CMP_NE:  flag_cmp = ~a_eq_b;
      exec_pkg::CMP_GTU: flag_cmp = ~(a_eq_b | a_ltu_b);
      exec_pkg::CMP_GEU: flag_cmp = ~a_ltu_b;
      exec_pkg::CMP_LTU: flag_cmp = a_ltu_b;
      exec_pkg::CMP_LEU: flag_cmp = a_eq_b | a_ltu_b;
      exec_pkg::CMP_GTS: flag_cmp = ~(a_eq_b | a_lts_b);
      exec_pkg::CMP_GES: flag_cmp = ~a_lts_b;
      exec_pkg::CMP_LTS: flag_cmp = a_lts_b;
      exec_pkg::CMP_LES: flag_cmp = a_eq_b | a_lts_b;
      default:           flag_cmp = 1'b0;
    endcase
  end

  // truth table indexed by {a, b}
  always_comb begin
    case (alu_ctrl_i.opc_alu)
      exec_pkg::ALU_OPC_AND: logic_lut = 4'b1000;
      exec_pkg::ALU_OPC_OR:  logic_lut = 4'b1110;
      exec_pkg::ALU_OPC_XOR: logic_lut = 4'b0110;
      default:               logic_lut = 4'b0000;
    endcase
    for (int i = 0; i < exec_pkg::DATA_W; i++) begin
      logic_res[i] = logic_lut[{op_a[i], op_b[i]}];
    end
  end

  // left shift runs through the right shifter on reversed bits
  assign shr_opc     = alu_ctrl_i.opc_secondary[1:0];
  assign shift_lsw   = (shr_opc == exec_pkg::SHR_SLL) ? bit_rev(op_a) : op_a;
  assign shift_msw   = (shr_opc == exec_pkg::SHR_SRA) ? {exec_pkg::DATA_W{op_a[31]}} :
                       (shr_opc == exec_pkg::SHR_ROR) ? op_a : '0;
  assign shift_right = exec_pkg::word_t'({shift_msw, shift_lsw} >> op_b[4:0]);
  assign shift_res   = (shr_opc == exec_pkg::SHR_SLL) ? bit_rev(shift_right) : shift_right;

  // an empty truth table already gives zero
  assign res_mux = alu_ctrl_i.op_shift ? shift_res :
                   alu_ctrl_i.op_add   ? add_res   : logic_res;

  always_ff @(posedge clk) begin
    if (exec_insn_1clk_i && padv_wb_i) result_q <= res_mux;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rdy_q        <= 1'b0;
      flag_set_o   <= 1'b0;
      flag_clear_o <= 1'b0;
    end else if (pipeline_flush_i) begin
      flag_set_o   <= 1'b0;  // rdy holds
      flag_clear_o <= 1'b0;
    end else if (padv_wb_i) begin
      rdy_q        <= exec_insn_1clk_i;
      flag_set_o   <= alu_ctrl_i.op_setflag & flag_cmp;
      flag_clear_o <= alu_ctrl_i.op_setflag & ~flag_cmp;
    end
  end

  assign alu_res_o = '{result: result_q, rdy: rdy_q};

  // set-flag relations only hold for the subtract
  a_setflag_sub: assert property (@(posedge clk) disable iff (rst)
    padv_wb_i && alu_ctrl_i.op_setflag |-> alu_ctrl_i.do_sub);

endmodule

// File: hdl/exec_div_serial.sv
`timescale 1ns/1ps
/*
  Serial restoring divider, signed or unsigned, one quotient bit per cycle.
  Operands come from rfa and rfb; the quotient registers on padv_wb_i.
  Divide-by-zero and success status are qualified by div_valid_o.
*/
module exec_div_serial (
  input  logic                clk,
  input  logic                rst,
  input  logic                padv_wb_i,
  input  logic                pipeline_flush_i,
  input  exec_pkg::operands_t operands_i,
  input  logic                op_div_i,
  input  logic                op_div_signed_i,
  input  logic                op_div_unsigned_i,
  output logic                take_op_div_o,
  output logic                div_busy_o,
  output logic                div_valid_o,
  output exec_pkg::unit_res_t div_res_o,
  output logic                div_dbz_signed_o,
  output logic                div_dbz_unsigned_o,
  output logic                div_ok_signed_o,
  output logic                div_ok_unsigned_o
);

  logic [exec_pkg::DIV_CNT_W-1:0] div_count;
  exec_pkg::word_t                div_n;    // dividend, becomes quotient
  exec_pkg::word_t                div_d;
  exec_pkg::word_t                div_r;    // partial remainder
  exec_pkg::word_t                quot;
  exec_pkg::word_t                result_q;
  logic [exec_pkg::DATA_W+1:0]    div_sub;
  logic                           rdy_q;
  logic                           sign_a;
  logic                           sign_b;
  logic                           div_neg;
  logic                           dbz_q;
  logic                           signed_q;
  logic                           unsigned_q;

  assign take_op_div_o = op_div_i & (div_valid_o ? padv_wb_i : ~div_busy_o);

  always_ff @(posedge clk) begin
    if (rst || pipeline_flush_i) begin
      div_valid_o <= 1'b0;
      div_busy_o  <= 1'b0;
      div_count   <= '0;
    end else if (take_op_div_o) begin
      div_valid_o <= 1'b0;
      div_busy_o  <= 1'b1;
      div_count   <= exec_pkg::DIV_CNT_W'(exec_pkg::DATA_W);
    end else if (div_valid_o && padv_wb_i) begin
      div_valid_o <= 1'b0;  // result leaves
    end else if (div_busy_o) begin
      if (div_count == exec_pkg::DIV_CNT_W'(1)) begin
        div_valid_o <= 1'b1;
        div_busy_o  <= 1'b0;
      end
      div_count <= div_count - 1'b1;
    end
  end

  assign sign_a  = operands_i.rfa[exec_pkg::DATA_W-1] & op_div_signed_i;
  assign sign_b  = operands_i.rfb[exec_pkg::DATA_W-1] & op_div_signed_i;
  // trial subtract, top bit is the borrow
  assign div_sub = {1'b0, div_r, div_n[exec_pkg::DATA_W-1]} - {2'b00, div_d};

  always_ff @(posedge clk) begin
    if (take_op_div_o) begin
      div_n      <= (operands_i.rfa ^ {exec_pkg::DATA_W{sign_a}}) +
                    exec_pkg::word_t'(sign_a);
      div_d      <= (operands_i.rfb ^ {exec_pkg::DATA_W{sign_b}}) +
                    exec_pkg::word_t'(sign_b);
      div_r      <= '0;
      div_neg    <= sign_a ^ sign_b;
      dbz_q      <= ~(|operands_i.rfb);
      signed_q   <= op_div_signed_i;
      unsigned_q <= op_div_unsigned_i;
    end else if (div_busy_o) begin
      if (!div_sub[exec_pkg::DATA_W+1]) begin
        div_r <= div_sub[exec_pkg::DATA_W-1:0];
        div_n <= {div_n[exec_pkg::DATA_W-2:0], 1'b1};
      end else begin
        div_r <= {div_r[exec_pkg::DATA_W-2:0], div_n[exec_pkg::DATA_W-1]};
        div_n <= {div_n[exec_pkg::DATA_W-2:0], 1'b0};
      end
    end
  end

  assign quot = (div_n ^ {exec_pkg::DATA_W{div_neg}}) + exec_pkg::word_t'(div_neg);

  always_ff @(posedge clk) begin
    if (div_valid_o && padv_wb_i) result_q <= quot;
  end

  always_ff @(posedge clk) begin
    if (rst) rdy_q <= 1'b0;
    else if (padv_wb_i && !pipeline_flush_i) rdy_q <= div_valid_o;
  end

  assign div_res_o          = '{result: result_q, rdy: rdy_q};
  assign div_dbz_signed_o   = div_valid_o & signed_q & dbz_q;
  assign div_ok_signed_o    = div_valid_o & signed_q & ~dbz_q;
  assign div_dbz_unsigned_o = div_valid_o & unsigned_q & dbz_q;
  assign div_ok_unsigned_o  = div_valid_o & unsigned_q & ~dbz_q;

  a_busy_valid: assert property (@(posedge clk) disable iff (rst)
    !(div_busy_o && div_valid_o));

endmodule

// File: hdl/exec_mul_pipe.sv
`timescale 1ns/1ps
/*
  Three-stage pipelined 32-bit multiplier giving the low product word.
  Half words, then partial products, then the sum registered for writeback.
  The pipe stalls as a whole while its last stage waits for padv_wb_i.
*/
module exec_mul_pipe (
  input  logic                clk,
  input  logic                rst,
  input  logic                padv_wb_i,
  input  logic                pipeline_flush_i,
  input  exec_pkg::operands_t operands_i,
  input  logic                op_mul_i,
  output logic                take_op_mul_o,
  output logic                mul_busy_o,
  output logic                mul_valid_o,
  output exec_pkg::unit_res_t mul_res_o
);

  exec_pkg::word_t                op_b;
  logic [exec_pkg::DATA_W/2-1:0] s1_al;
  logic [exec_pkg::DATA_W/2-1:0] s1_ah;
  logic [exec_pkg::DATA_W/2-1:0] s1_bl;
  logic [exec_pkg::DATA_W/2-1:0] s1_bh;
  exec_pkg::word_t                s2_albl;
  exec_pkg::word_t                s2_ahbl;
  exec_pkg::word_t                s2_bhal;
  exec_pkg::word_t                s3_sum;
  exec_pkg::word_t                result_q;
  logic                           rdy_q;
  logic                           s1_rdy;
  logic                           s2_rdy;
  logic                           mul_adv;

  assign op_b = operands_i.imm_sel ? operands_i.immediate : operands_i.rfb;

  assign mul_valid_o   = s2_rdy;  // one cycle ahead of the wb latch
  assign mul_adv       = ~mul_valid_o | padv_wb_i;
  assign take_op_mul_o = op_mul_i & mul_adv;
  assign mul_busy_o    = op_mul_i & ~mul_adv;

  always_ff @(posedge clk) begin
    if (mul_adv) begin
      s1_al   <= operands_i.rfa[exec_pkg::DATA_W/2-1:0];
      s1_ah   <= operands_i.rfa[exec_pkg::DATA_W-1:exec_pkg::DATA_W/2];
      s1_bl   <= op_b[exec_pkg::DATA_W/2-1:0];
      s1_bh   <= op_b[exec_pkg::DATA_W-1:exec_pkg::DATA_W/2];
      s2_albl <= s1_al * s1_bl;
      s2_ahbl <= s1_ah * s1_bl;
      s2_bhal <= s1_bh * s1_al;
    end
  end

  // high-by-high product falls outside the low word
  assign s3_sum = {s2_bhal[exec_pkg::DATA_W/2-1:0], {(exec_pkg::DATA_W/2){1'b0}}} +
                  {s2_ahbl[exec_pkg::DATA_W/2-1:0], {(exec_pkg::DATA_W/2){1'b0}}} +
                  s2_albl;

  always_ff @(posedge clk) begin
    if (mul_valid_o && padv_wb_i) result_q <= s3_sum;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_rdy <= 1'b0;
      s2_rdy <= 1'b0;
      rdy_q  <= 1'b0;
    end else if (pipeline_flush_i) begin
      s1_rdy <= 1'b0;
      s2_rdy <= 1'b0;
    end else begin
      if (mul_adv) begin
        s1_rdy <= op_mul_i;
        s2_rdy <= s1_rdy;
      end
      if (padv_wb_i) rdy_q <= mul_valid_o;
    end
  end

  assign mul_res_o = '{result: result_q, rdy: rdy_q};

  // a stalled last stage keeps its product until writeback takes it
  a_stall_hold: assert property (@(posedge clk) disable iff (rst || pipeline_flush_i)
    mul_valid_o && !padv_wb_i |=> mul_valid_o && $stable(s3_sum));

endmodule

// File: hdl/exec_pkg.sv
/*
  Shared widths, opcode codes and packed structs of the integer execute stage.
  RTL and testbench refer to these by scoped names.
*/
package exec_pkg;

  localparam int DATA_W    = 32;
  localparam int RF_ADR_W  = 5;
  localparam int ALU_OPC_W = 4;
  localparam int SEC_OPC_W = 4;
  localparam int DIV_CNT_W = 6;

  typedef logic [DATA_W-1:0]   word_t;
  typedef logic [RF_ADR_W-1:0] rf_adr_t;

  // primary opcodes of the logic unit
  localparam logic [ALU_OPC_W-1:0] ALU_OPC_AND = 4'h3;
  localparam logic [ALU_OPC_W-1:0] ALU_OPC_OR  = 4'h4;
  localparam logic [ALU_OPC_W-1:0] ALU_OPC_XOR = 4'h5;

  // set-flag comparisons, secondary opcode
  localparam logic [SEC_OPC_W-1:0] CMP_EQ  = 4'd0;
  localparam logic [SEC_OPC_W-1:0] CMP_NE  = 4'd1;
  localparam logic [SEC_OPC_W-1:0] CMP_GTU = 4'd2;
  localparam logic [SEC_OPC_W-1:0] CMP_GEU = 4'd3;
  localparam logic [SEC_OPC_W-1:0] CMP_LTU = 4'd4;
  localparam logic [SEC_OPC_W-1:0] CMP_LEU = 4'd5;
  localparam logic [SEC_OPC_W-1:0] CMP_GTS = 4'd10;
  localparam logic [SEC_OPC_W-1:0] CMP_GES = 4'd11;
  localparam logic [SEC_OPC_W-1:0] CMP_LTS = 4'd12;
  localparam logic [SEC_OPC_W-1:0] CMP_LES = 4'd13;

  // shift kinds, low two secondary bits
  localparam logic [1:0] SHR_SLL = 2'd0;
  localparam logic [1:0] SHR_SRL = 2'd1;
  localparam logic [1:0] SHR_SRA = 2'd2;
  localparam logic [1:0] SHR_ROR = 2'd3;

  typedef struct packed {
    word_t rfa;
    word_t rfb;
    word_t immediate;
    logic  imm_sel;    // B is the immediate
  } operands_t;

  typedef struct packed {
    logic [ALU_OPC_W-1:0] opc_alu;
    logic [SEC_OPC_W-1:0] opc_secondary;
    logic                 op_add;
    logic                 do_sub;
    logic                 do_carry;
    logic                 carry_in;   // current carry flag
    logic                 op_shift;
    logic                 op_setflag;
  } alu_ctrl_t;

  typedef struct packed {
    rf_adr_t rfd_adr;
    logic    rf_wb;
    logic    bubble;
  } insn_info_t;

  typedef struct packed {
    logic flag_set;
    logic flag_clear;
    logic carry_set;
    logic carry_clear;
    logic ovf_set;
    logic ovf_clear;
  } wb_flags_t;

  typedef struct packed {
    word_t result;
    logic  rdy;
  } unit_res_t;

endpackage

// File: hdl/exec_top.sv
`timescale 1ns/1ps
/*
  Integer execute stage top: one-cycle ALU, pipelined multiplier and serial
  divider feeding one set of writeback registers.
*/
module exec_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 padv_wb_i,
  input  logic                 pipeline_flush_i,
  input  exec_pkg::operands_t  operands_i,
  input  exec_pkg::alu_ctrl_t  alu_ctrl_i,
  input  exec_pkg::insn_info_t insn_i,
  input  logic                 exec_insn_1clk_i,
  input  logic                 op_mul_i,
  input  logic                 op_div_i,
  input  logic                 op_div_signed_i,
  input  logic                 op_div_unsigned_i,
  output logic                 exec_valid_o,
  output logic                 take_op_mul_o,
  output logic                 mul_busy_o,
  output logic                 take_op_div_o,
  output logic                 div_busy_o,
  output exec_pkg::word_t      wb_result_o,
  output exec_pkg::wb_flags_t  wb_flags_o,
  output exec_pkg::rf_adr_t    wb_rfd_adr_o,
  output logic                 wb_rf_wb_o
);

  exec_pkg::unit_res_t alu_res;
  exec_pkg::unit_res_t mul_res;
  exec_pkg::unit_res_t div_res;
  logic                flag_set;
  logic                flag_clear;
  logic                add_carry;
  logic                add_ovf;
  logic                mul_valid;
  logic                div_valid;
  logic                dbz_signed;
  logic                dbz_unsigned;
  logic                ok_signed;
  logic                ok_unsigned;

  assign exec_valid_o = exec_insn_1clk_i | mul_valid | div_valid;

  exec_alu_1clk alu0 (
    .clk, .rst, .padv_wb_i, .pipeline_flush_i, .operands_i, .alu_ctrl_i,
    .exec_insn_1clk_i,
    .alu_res_o    (alu_res),
    .flag_set_o   (flag_set),
    .flag_clear_o (flag_clear),
    .add_carry_o  (add_carry),
    .add_ovf_o    (add_ovf)
  );

  exec_mul_pipe mul0 (
    .clk, .rst, .padv_wb_i, .pipeline_flush_i, .operands_i, .op_mul_i,
    .take_op_mul_o, .mul_busy_o,
    .mul_valid_o (mul_valid),
    .mul_res_o   (mul_res)
  );

  exec_div_serial div0 (
    .clk, .rst, .padv_wb_i, .pipeline_flush_i, .operands_i,
    .op_div_i, .op_div_signed_i, .op_div_unsigned_i, .take_op_div_o, .div_busy_o,
    .div_valid_o        (div_valid),
    .div_res_o          (div_res),
    .div_dbz_signed_o   (dbz_signed),
    .div_dbz_unsigned_o (dbz_unsigned),
    .div_ok_signed_o    (ok_signed),
    .div_ok_unsigned_o  (ok_unsigned)
  );

  exec_wb_regs wb0 (
    .clk, .rst, .padv_wb_i, .pipeline_flush_i, .insn_i, .alu_ctrl_i,
    .add_carry_i        (add_carry),
    .add_ovf_i          (add_ovf),
    .alu_res_i          (alu_res),
    .mul_res_i          (mul_res),
    .div_res_i          (div_res),
    .div_dbz_signed_i   (dbz_signed),
    .div_dbz_unsigned_i (dbz_unsigned),
    .div_ok_signed_i    (ok_signed),
    .div_ok_unsigned_i  (ok_unsigned),
    .flag_set_i         (flag_set),
    .flag_clear_i       (flag_clear),
    .wb_result_o, .wb_flags_o, .wb_rfd_adr_o, .wb_rf_wb_o
  );

endmodule

// File: hdl/exec_wb_regs.sv
`timescale 1ns/1ps
/*
  Writeback stage registers: result mux over the unit results, carry and
  overflow set/clear pulses, destination register tag and write request.
*/
module exec_wb_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 padv_wb_i,
  input  logic                 pipeline_flush_i,
  input  exec_pkg::insn_info_t insn_i,
  input  exec_pkg::alu_ctrl_t  alu_ctrl_i,
  input  logic                 add_carry_i,
  input  logic                 add_ovf_i,
  input  exec_pkg::unit_res_t  alu_res_i,
  input  exec_pkg::unit_res_t  mul_res_i,
  input  exec_pkg::unit_res_t  div_res_i,
  input  logic                 div_dbz_signed_i,
  input  logic                 div_dbz_unsigned_i,
  input  logic                 div_ok_signed_i,
  input  logic                 div_ok_unsigned_i,
  input  logic                 flag_set_i,
  input  logic                 flag_clear_i,
  output exec_pkg::word_t      wb_result_o,
  output exec_pkg::wb_flags_t  wb_flags_o,
  output exec_pkg::rf_adr_t    wb_rfd_adr_o,
  output logic                 wb_rf_wb_o
);

  logic carry_set_q;
  logic carry_clear_q;
  logic ovf_set_q;
  logic ovf_clear_q;

  // one-cycle ALU first, then multiplier, then divider
  assign wb_result_o = alu_res_i.rdy ? alu_res_i.result :
                       mul_res_i.rdy ? mul_res_i.result :
                       div_res_i.rdy ? div_res_i.result : '0;

  always_ff @(posedge clk) begin
    if (rst || pipeline_flush_i) begin
      carry_set_q   <= 1'b0;
      carry_clear_q <= 1'b0;
      ovf_set_q     <= 1'b0;
      ovf_clear_q   <= 1'b0;
      wb_rf_wb_o    <= 1'b0;
    end else if (padv_wb_i) begin
      carry_set_q   <= (alu_ctrl_i.op_add & add_carry_i) | div_dbz_unsigned_i;
      carry_clear_q <= (alu_ctrl_i.op_add & ~add_carry_i) | div_ok_unsigned_i;
      ovf_set_q     <= (alu_ctrl_i.op_add & add_ovf_i) | div_dbz_signed_i;
      ovf_clear_q   <= (alu_ctrl_i.op_add & ~add_ovf_i) | div_ok_signed_i;
      wb_rf_wb_o    <= insn_i.rf_wb;
    end
  end

  // bubbles keep the previous tag
  always_ff @(posedge clk) begin
    if (padv_wb_i && !pipeline_flush_i && !insn_i.bubble) wb_rfd_adr_o <= insn_i.rfd_adr;
  end

  assign wb_flags_o = '{flag_set:    flag_set_i,
                        flag_clear:  flag_clear_i,
                        carry_set:   carry_set_q,
                        carry_clear: carry_clear_q,
                        ovf_set:     ovf_set_q,
                        ovf_clear:   ovf_clear_q};

endmodule

// File: verification/exec_cases.txt
# kind rfa rfb imm isel alu sec add sub cry cin shf setf dsg rd chk result flags
# flags bits: flag_set flag_clear carry_set carry_clear ovf_set ovf_clear
alu 00000005 00000003 00000000 0 0 0 1 0 0 0 0 0 0 1 1 00000008 000101
alu ffffffff 00000001 00000000 0 0 0 1 0 0 0 0 0 0 2 1 00000000 001001
alu 7fffffff 00000001 00000000 0 0 0 1 0 0 0 0 0 0 3 1 80000000 000110
alu 00000005 00000007 00000000 0 0 0 1 1 0 0 0 0 0 4 1 fffffffe 000101
alu 80000000 deadbeef 00000001 1 0 0 1 1 0 0 0 0 0 5 1 7fffffff 001010
alu 00000010 00000020 00000000 0 0 0 1 0 1 1 0 0 0 6 1 00000031 000101
alu 00000005 00000005 00000000 0 0 0 0 1 0 0 0 1 0 7 0 00000000 100000
alu 00000005 00000005 00000000 0 0 1 0 1 0 0 0 1 0 8 0 00000000 010000
alu ffffffff 00000001 00000000 0 0 2 0 1 0 0 0 1 0 9 0 00000000 100000
alu 00000001 00000002 00000000 0 0 3 0 1 0 0 0 1 0 10 0 00000000 010000
alu 00000001 ffffffff 00000000 0 0 4 0 1 0 0 0 1 0 11 0 00000000 100000
alu 00000003 00000003 00000000 0 0 5 0 1 0 0 0 1 0 12 0 00000000 100000
alu ffffffff 00000001 00000000 0 0 a 0 1 0 0 0 1 0 13 0 00000000 010000
alu 00000001 80000000 00000000 0 0 b 0 1 0 0 0 1 0 14 0 00000000 100000
alu 80000000 7fffffff 00000000 0 0 c 0 1 0 0 0 1 0 15 0 00000000 100000
alu 00000005 fffffffd 00000000 0 0 d 0 1 0 0 0 1 0 16 0 00000000 010000
alu f0f0f0f0 ff00ff00 00000000 0 3 0 0 0 0 0 0 0 0 17 1 f000f000 000000
alu 12340000 ffffffff 00005678 1 4 0 0 0 0 0 0 0 0 18 1 12345678 000000
alu aaaa5555 ffff0000 00000000 0 5 0 0 0 0 0 0 0 0 19 1 55555555 000000
alu 00000001 00000024 00000000 0 0 0 0 0 0 0 1 0 0 20 1 00000010 000000
alu 80000000 0000001f 00000000 0 0 1 0 0 0 0 1 0 0 21 1 00000001 000000
alu 80000000 ffffffff 00000004 1 0 2 0 0 0 0 1 0 0 22 1 f8000000 000000
alu 12345678 00000008 00000000 0 0 3 0 0 0 0 1 0 0 23 1 78123456 000000
mul 00000007 00000006 00000000 0 0 0 0 0 0 0 0 0 0 24 1 0000002a 000000
mul ffffffff ffffffff 00000000 0 0 0 0 0 0 0 0 0 0 25 1 00000001 000000
mul 12345678 00000000 00000100 1 0 0 0 0 0 0 0 0 0 26 1 34567800 000000
mul 00010000 00010000 00000000 0 0 0 0 0 0 0 0 0 0 27 1 00000000 000000
div 00000064 00000007 00000000 0 0 0 0 0 0 0 0 0 0 28 1 0000000e 000100
div ffffff9c 00000007 00000000 0 0 0 0 0 0 0 0 0 1 29 1 fffffff2 000001
div 00000064 fffffff9 00000000 0 0 0 0 0 0 0 0 0 1 30 1 fffffff2 000001
div ffffff9c fffffff9 00000000 0 0 0 0 0 0 0 0 0 1 31 1 0000000e 000001
div 00000005 00000000 00000000 0 0 0 0 0 0 0 0 0 0 1 1 ffffffff 001000
div fffffffb 00000000 00000000 0 0 0 0 0 0 0 0 0 1 2 1 00000001 000010
div ffffffff 00000010 00000000 0 0 0 0 0 0 0 0 0 0 3 1 0fffffff 000100

// File: include/exec_tb_checks.svh
/*
  Compare tasks and error counters for the execute-stage testbench.
  Included inside the testbench module; each mismatch bumps a counter.
*/
`ifndef EXEC_TB_CHECKS_SVH
`define EXEC_TB_CHECKS_SVH

int err_result  = 0;
int err_flags   = 0;
int err_timeout = 0;

task automatic check_result(input exec_pkg::word_t got, input exec_pkg::word_t exp,
                            input string msg);
  if (got !== exp) begin
    err_result++;
    $display("Fail at %0t: %s result %h, expected %h", $time, msg, got, exp);
  end
endtask

task automatic check_flags(input exec_pkg::wb_flags_t got, input exec_pkg::wb_flags_t exp,
                           input string msg);
  if (got !== exp) begin
    err_flags++;
    $display("Fail at %0t: %s flags %b, expected %b", $time, msg, got, exp);
  end
endtask

task automatic report_timeout(input string what);
  err_timeout++;
  $display("Fail at %0t: timeout waiting for %s", $time, what);
endtask

`endif

// File: verification/exec_tb.sv
`timescale 1ns/1ps
/*
  Testbench for the integer execute stage. Reads one operation per line from
  the case file, drives it on falling edges, waits for take and valid, pulses
  padv_wb_i and compares writeback outputs. Ends with a multiplier stall and
  a seeded multiply burst.
*/
module exec_tb;

  `include "exec_tb_checks.svh"

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 padv_wb;
  logic                 flush;
  exec_pkg::operands_t  operands;
  exec_pkg::alu_ctrl_t  alu_ctrl;
  exec_pkg::insn_info_t insn;
  logic                 exec_insn_1clk;
  logic                 op_mul;
  logic                 op_div;
  logic                 op_div_signed;
  logic                 op_div_unsigned;
  logic                 exec_valid;
  logic                 take_op_mul;
  logic                 mul_busy;
  logic                 take_op_div;
  logic                 div_busy;
  exec_pkg::word_t      wb_result;
  exec_pkg::wb_flags_t  wb_flags;
  exec_pkg::rf_adr_t    wb_rfd_adr;
  logic                 wb_rf_wb;

  logic            take_mul_seen;
  logic            take_div_seen;
  logic            wb_fire;
  logic            burst_on = 1'b0;
  int              err_tag  = 0;
  int              err_misc = 0;
  int              seed     = 32'h9195d862;
  exec_pkg::word_t mul_expect[$];  // burst products, in take order

  always #50 clk = ~clk;

  exec_top dut0 (
    .clk, .rst,
    .padv_wb_i         (padv_wb),
    .pipeline_flush_i  (flush),
    .operands_i        (operands),
    .alu_ctrl_i        (alu_ctrl),
    .insn_i            (insn),
    .exec_insn_1clk_i  (exec_insn_1clk),
    .op_mul_i          (op_mul),
    .op_div_i          (op_div),
    .op_div_signed_i   (op_div_signed),
    .op_div_unsigned_i (op_div_unsigned),
    .exec_valid_o      (exec_valid),
    .take_op_mul_o     (take_op_mul),
    .mul_busy_o        (mul_busy),
    .take_op_div_o     (take_op_div),
    .div_busy_o        (div_busy),
    .wb_result_o       (wb_result),
    .wb_flags_o        (wb_flags),
    .wb_rfd_adr_o      (wb_rfd_adr),
    .wb_rf_wb_o        (wb_rf_wb)
  );

  // handshake seen at the rising edge, read back on the falling edge
  always @(posedge clk) begin
    take_mul_seen <= take_op_mul;
    take_div_seen <= take_op_div;
    wb_fire       <= padv_wb & exec_valid;
    if (burst_on && take_op_mul) begin
      mul_expect.push_back(exec_pkg::word_t'(operands.rfa * operands.rfb));
    end
  end

  task automatic check_tag(input exec_pkg::rf_adr_t got_adr, input logic got_wb,
                           input exec_pkg::rf_adr_t exp_adr, input string msg);
    if (got_adr !== exp_adr || got_wb !== 1'b1) begin
      err_tag++;
      $display("Fail at %0t: %s tag %0d wb %b, expected %0d wb 1", $time, msg,
               got_adr, got_wb, exp_adr);
    end
  endtask

  task automatic check_idle(input string msg);
    if ({exec_valid, take_op_mul, mul_busy, take_op_div, div_busy, wb_rf_wb} !== 6'b0) begin
      err_misc++;
      $display("Fail at %0t: %s status not idle", $time, msg);
    end
  endtask

  task automatic wait_take(input logic is_div, output logic ok);
    ok = 1'b0;
    for (int n = 0; n < 20 && !ok; n++) begin
      @(negedge clk);
      ok = is_div ? take_div_seen : take_mul_seen;
    end
    if (!ok) report_timeout(is_div ? "divider take" : "multiplier take");
  endtask

  task automatic wait_valid(output logic ok);
    ok = 1'b0;
    for (int n = 0; n < 40 && !ok; n++) begin
      @(negedge clk);
      ok = exec_valid;
    end
    if (!ok) report_timeout("exec_valid_o");
  endtask

  task automatic run_case(input string kind, input exec_pkg::operands_t ops,
                          input exec_pkg::alu_ctrl_t ctrl, input logic dsg,
                          input exec_pkg::rf_adr_t rd, input logic chk,
                          input exec_pkg::word_t exp_res, input exec_pkg::wb_flags_t exp_flags);
    logic  ok;
    string msg;
    msg             = $sformatf("%s %h %h %h", kind, ops.rfa, ops.rfb, ops.immediate);
    ok              = 1'b1;
    operands        = ops;
    alu_ctrl        = ctrl;
    insn            = '{rfd_adr: rd, rf_wb: 1'b1, bubble: 1'b0};
    op_div_signed   = (kind == "div") & dsg;
    op_div_unsigned = (kind == "div") & ~dsg;
    if (kind == "alu") exec_insn_1clk = 1'b1;
    else if (kind == "mul") op_mul = 1'b1;
    else op_div = 1'b1;
    if (kind != "alu") begin
      wait_take(kind == "div", ok);
      op_mul = 1'b0;  // strobe drops after the take
      op_div = 1'b0;
      if (ok && kind == "div" && div_busy !== 1'b1) begin
        err_misc++;
        $display("Fail at %0t: %s divider not busy after take", $time, msg);
      end
    end
    if (ok) wait_valid(ok);
    if (ok) begin
      padv_wb = 1'b1;
      @(negedge clk);
      padv_wb        = 1'b0;
      exec_insn_1clk = 1'b0;
      if (chk) check_result(wb_result, exp_res, msg);
      check_flags(wb_flags, exp_flags, msg);
      check_tag(wb_rfd_adr, wb_rf_wb, rd, msg);
    end
    exec_insn_1clk = 1'b0;
    op_mul         = 1'b0;
    op_div         = 1'b0;
    padv_wb        = 1'b0;
  endtask

  // writeback held off until the multiplier pushes back, results drain in the burst
  task automatic mul_stall();
    int n;
    burst_on = 1'b1;
    alu_ctrl = '0;
    padv_wb  = 1'b0;
    op_mul   = 1'b1;
    n        = 0;
    while (!mul_busy && n < 20) begin
      operands = '{rfa: $random(seed), rfb: $random(seed), immediate: '0, imm_sel: 1'b0};
      @(negedge clk);
      n++;
    end
    if (!mul_busy) begin
      report_timeout("multiplier busy");
    end else begin
      repeat (3) begin
        @(negedge clk);
        if (mul_busy !== 1'b1 || take_mul_seen !== 1'b0 || exec_valid !== 1'b1) begin
          err_misc++;
          $display("Fail at %0t: multiplier did not hold under back-pressure", $time);
        end
      end
    end
    op_mul = 1'b0;
  endtask

  // back-to-back multiplies with writeback advancing every cycle
  task automatic mul_burst(input int count);
    int              sent;
    int              idle;
    exec_pkg::word_t exp;
    sent     = 0;
    idle     = 0;
    burst_on = 1'b1;
    alu_ctrl = '0;
    padv_wb  = 1'b1;
    while ((sent < count || mul_expect.size() > 0) && idle < 40) begin
      if (sent < count) begin
        operands = '{rfa: $random(seed), rfb: $random(seed), immediate: '0, imm_sel: 1'b0};
        op_mul   = 1'b1;
        sent++;
      end else begin
        op_mul = 1'b0;
      end
      @(negedge clk);
      if (wb_fire) begin
        idle = 0;
        if (mul_expect.size() == 0) begin
          err_misc++;
          $display("Fail at %0t: multiplier result with no multiply pending", $time);
        end else begin
          exp = mul_expect.pop_front();
          check_result(wb_result, exp, "mul burst");
        end
      end else begin
        idle++;
      end
    end
    if (idle >= 40) report_timeout("multiplier burst results");
    op_mul   = 1'b0;
    padv_wb  = 1'b0;
    burst_on = 1'b0;
  endtask

  initial begin
    int              fd;
    int              n;
    int              total;
    string           line;
    string           kind;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     imm;
    logic [31:0]     res;
    logic [3:0]      alu;
    logic [3:0]      sec;
    int              isel;
    int              add;
    int              sub;
    int              cry;
    int              cin;
    int              shf;
    int              setf;
    int              dsg;
    int              rd;
    int              chk;
    logic [5:0]      flags;
    rst             = 1'b1;
    padv_wb         = 1'b0;
    flush           = 1'b0;
    operands        = '0;
    alu_ctrl        = '0;
    insn            = '0;
    exec_insn_1clk  = 1'b0;
    op_mul          = 1'b0;
    op_div          = 1'b0;
    op_div_signed   = 1'b0;
    op_div_unsigned = 1'b0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    check_idle("after reset");
    check_flags(wb_flags, '0, "after reset");

    fd = $fopen("verification/exec_cases.txt", "r");
    if (fd == 0) begin
      err_misc++;
      $display("could not open the case file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (line.len() < 2 || line[0] == "#") continue;  // header and blank lines
        n = $sscanf(line, "%s %h %h %h %d %h %h %d %d %d %d %d %d %d %d %d %h %b",
                    kind, a, b, imm, isel, alu, sec, add, sub, cry, cin, shf, setf,
                    dsg, rd, chk, res, flags);
        if (n != 18) begin
          err_misc++;
          $display("malformed line in the case file: %s", line);
          continue;
        end
        run_case(kind,
                 '{rfa: a, rfb: b, immediate: imm, imm_sel: isel[0]},
                 '{opc_alu: alu, opc_secondary: sec, op_add: add[0], do_sub: sub[0],
                   do_carry: cry[0], carry_in: cin[0], op_shift: shf[0],
                   op_setflag: setf[0]},
                 dsg[0], exec_pkg::rf_adr_t'(rd), chk[0], res, exec_pkg::wb_flags_t'(flags));
      end
      $fclose(fd);
    end

    mul_stall();
    mul_burst(16);

    total = err_result + err_flags + err_tag + err_misc + err_timeout;
    $display("errors: result %0d, flags %0d, tag %0d, other %0d, timeout %0d",
             err_result, err_flags, err_tag, err_misc, err_timeout);
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
